//--- hw/div_pkg.sv
package div_pkg;

	// operand widths
	localparam int DIVISOR_W = 16;
	localparam int DIVIDEND_W = 2 * DIVISOR_W;

	typedef logic [DIVISOR_W-1:0] divisor_t;
	typedef logic [DIVIDEND_W-1:0] dividend_t;

	// partial remainder, top bit is the sign
	typedef logic [DIVISOR_W:0] prem_t;

	// quotient collected msb first
	typedef logic [DIVISOR_W-1:0] quot_t;

	// quotient or remainder, as mode picks
	typedef logic [DIVISOR_W-1:0] result_t;

endpackage

//--- hw/cas_row.sv
`timescale 1ns/1ps

module cas_row import div_pkg::*; (
	input  logic     sub,
	input  divisor_t divisor,
	input  prem_t    prem_in,
	input  logic     next_bit,
	output prem_t    prem_out,
	output logic     q_bit
);

	prem_t shifted;
	prem_t divisor_ext;

	wire [DIVISOR_W:0] sum;
	wire [DIVISOR_W:0] carry;

	// shift left, next dividend bit enters at the bottom
	assign shifted = {prem_in[DIVISOR_W-1:0], next_bit};
	assign divisor_ext = {1'b0, divisor};

	// subtract is invert plus carry in
	assign carry[0] = sub;

	genvar i;
	generate
		for (i = 0; i <= DIVISOR_W; i++) begin : g_cell
			wire b;

			// controlled inverter
			assign b = divisor_ext[i] ^ sub;

			// full adder
			assign sum[i] = shifted[i] ^ b ^ carry[i];
			if (i < DIVISOR_W) begin : g_carry
				assign carry[i+1] = (shifted[i] & b) | (carry[i] & (shifted[i] ^ b));
			end
		end
	endgenerate

	assign prem_out = sum;

	// non-negative remainder gives a one
	assign q_bit = ~sum[DIVISOR_W];

endmodule

//--- hw/div_stage.sv
`timescale 1ns/1ps

module div_stage import div_pkg::*; #(
	parameter int ROWS_PER_STAGE = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	input  logic      in_mode,
	input  logic      in_sub,
	input  divisor_t  in_divisor,
	input  prem_t     in_prem,
	input  dividend_t in_rest,
	input  quot_t     in_quot,
	output logic      out_valid,
	output logic      out_mode,
	output logic      out_sub,
	output divisor_t  out_divisor,
	output prem_t     out_prem,
	output dividend_t out_rest,
	output quot_t     out_quot
);

	// values between the rows of this stage
	prem_t     prem_c [ROWS_PER_STAGE+1];
	logic      sub_c  [ROWS_PER_STAGE+1];
	dividend_t rest_c [ROWS_PER_STAGE+1];
	quot_t     quot_c [ROWS_PER_STAGE+1];

	assign prem_c[0] = in_prem;
	assign sub_c[0] = in_sub;
	assign rest_c[0] = in_rest;
	assign quot_c[0] = in_quot;

	genvar r;
	generate
		for (r = 0; r < ROWS_PER_STAGE; r++) begin : g_row
			cas_row u_row (
				.sub      (sub_c[r]),
				.divisor  (in_divisor),
				.prem_in  (prem_c[r]),
				.next_bit (rest_c[r][DIVIDEND_W-1]),
				.prem_out (prem_c[r+1]),
				.q_bit    (sub_c[r+1])
			);

			// consume one dividend bit
			assign rest_c[r+1] = {rest_c[r][DIVIDEND_W-2:0], 1'b0};

			// quotient bit goes in at the bottom
			assign quot_c[r+1] = {quot_c[r][DIVISOR_W-2:0], sub_c[r+1]};
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// payload follows the item, no reset
	always_ff @(posedge clk) begin
		out_mode <= in_mode;
		out_sub <= sub_c[ROWS_PER_STAGE];
		out_divisor <= in_divisor;
		out_prem <= prem_c[ROWS_PER_STAGE];
		out_rest <= rest_c[ROWS_PER_STAGE];
		out_quot <= quot_c[ROWS_PER_STAGE];
	end

endmodule

//--- hw/div_array.sv
`timescale 1ns/1ps

module div_array import div_pkg::*; #(
	parameter int ROWS_PER_STAGE = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      valid_input,
	input  logic      mode,
	input  dividend_t dividend,
	input  divisor_t  divisor,
	output logic      valid_q,
	output logic      mode_q,
	output divisor_t  divisor_q,
	output prem_t     prem_q,
	output quot_t     quot_q
);

	localparam int NUM_STAGES = DIVISOR_W / ROWS_PER_STAGE;

	logic      valid_c   [NUM_STAGES+1];
	logic      mode_c    [NUM_STAGES+1];
	divisor_t  divisor_c [NUM_STAGES+1];
	prem_t     prem_c    [NUM_STAGES+1];
	quot_t     quot_c    [NUM_STAGES+1];

	// only needed as stage inputs
	logic      sub_c     [NUM_STAGES];
	dividend_t rest_c    [NUM_STAGES];

	// first row starts from the high half and always subtracts
	assign valid_c[0] = valid_input;
	assign mode_c[0] = mode;
	assign divisor_c[0] = divisor;
	assign prem_c[0] = {1'b0, dividend[DIVIDEND_W-1:DIVISOR_W]};
	assign rest_c[0] = {dividend[DIVISOR_W-1:0], {DIVISOR_W{1'b0}}};
	assign sub_c[0] = 1'b1;
	assign quot_c[0] = '0;

	genvar s;
	generate
		for (s = 0; s < NUM_STAGES; s++) begin : g_stage
			if (s < NUM_STAGES - 1) begin : g_mid
				div_stage #(
					.ROWS_PER_STAGE (ROWS_PER_STAGE)
				) u_stage (
					.clk         (clk),
					.reset       (reset),
					.in_valid    (valid_c[s]),
					.in_mode     (mode_c[s]),
					.in_sub      (sub_c[s]),
					.in_divisor  (divisor_c[s]),
					.in_prem     (prem_c[s]),
					.in_rest     (rest_c[s]),
					.in_quot     (quot_c[s]),
					.out_valid   (valid_c[s+1]),
					.out_mode    (mode_c[s+1]),
					.out_sub     (sub_c[s+1]),
					.out_divisor (divisor_c[s+1]),
					.out_prem    (prem_c[s+1]),
					.out_rest    (rest_c[s+1]),
					.out_quot    (quot_c[s+1])
				);
			end else begin : g_last
				// dividend is used up and the last flag is already in the quotient
				div_stage #(
					.ROWS_PER_STAGE (ROWS_PER_STAGE)
				) u_stage (
					.clk         (clk),
					.reset       (reset),
					.in_valid    (valid_c[s]),
					.in_mode     (mode_c[s]),
					.in_sub      (sub_c[s]),
					.in_divisor  (divisor_c[s]),
					.in_prem     (prem_c[s]),
					.in_rest     (rest_c[s]),
					.in_quot     (quot_c[s]),
					.out_valid   (valid_c[s+1]),
					.out_mode    (mode_c[s+1]),
					.out_sub     (),
					.out_divisor (divisor_c[s+1]),
					.out_prem    (prem_c[s+1]),
					.out_rest    (),
					.out_quot    (quot_c[s+1])
				);
			end
		end
	endgenerate

	assign valid_q = valid_c[NUM_STAGES];
	assign mode_q = mode_c[NUM_STAGES];
	assign divisor_q = divisor_c[NUM_STAGES];
	assign prem_q = prem_c[NUM_STAGES];
	assign quot_q = quot_c[NUM_STAGES];

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ps

module result_stage import div_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_q,
	input  logic     mode_q,
	input  divisor_t divisor_q,
	input  prem_t    prem_q,
	input  quot_t    quot_q,
	output logic     valid_output,
	output result_t  final_output
);

	prem_t   corrected;
	result_t selected;

	// negative remainder gets the divisor added back
	always_comb begin
		if (prem_q[DIVISOR_W]) begin
			corrected = prem_q + {1'b0, divisor_q};
		end else begin
			corrected = prem_q;
		end
	end

	// mode high picks the quotient
	assign selected = mode_q ? quot_q : corrected[DIVISOR_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_output <= 1'b0;
		end else begin
			valid_output <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		final_output <= selected;
	end

endmodule

//--- hw/array_divider.sv
`timescale 1ns/1ps

module array_divider import div_pkg::*; #(
	parameter int ROWS_PER_STAGE = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      valid_input,
	input  dividend_t dividend,
	input  divisor_t  divisor,
	input  logic      mode,
	output logic      valid_output,
	output result_t   final_output
);

	// array to result stage
	logic     valid_q;
	logic     mode_q;
	divisor_t divisor_q;
	prem_t    prem_q;
	quot_t    quot_q;

	div_array #(
		.ROWS_PER_STAGE (ROWS_PER_STAGE)
	) u_array (
		.clk         (clk),
		.reset       (reset),
		.valid_input (valid_input),
		.mode        (mode),
		.dividend    (dividend),
		.divisor     (divisor),
		.valid_q     (valid_q),
		.mode_q      (mode_q),
		.divisor_q   (divisor_q),
		.prem_q      (prem_q),
		.quot_q      (quot_q)
	);

	result_stage u_result (
		.clk          (clk),
		.reset        (reset),
		.valid_q      (valid_q),
		.mode_q       (mode_q),
		.divisor_q    (divisor_q),
		.prem_q       (prem_q),
		.quot_q       (quot_q),
		.valid_output (valid_output),
		.final_output (final_output)
	);

endmodule

//--- bench/div_vectors.svh
`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// columns: name, dividend, divisor, mode, valid, expected final_output
// mode high asks for the quotient, mode low for the remainder

string     vec_name     [$];
dividend_t vec_dividend [$];
divisor_t  vec_divisor  [$];
logic      vec_mode     [$];
logic      vec_valid    [$];
result_t   vec_expected [$];

task automatic add_vector(string name, dividend_t dvd, divisor_t dvs, logic md, logic vld,
		result_t expected);
	vec_name.push_back(name);
	vec_dividend.push_back(dvd);
	vec_divisor.push_back(dvs);
	vec_mode.push_back(md);
	vec_valid.push_back(vld);
	vec_expected.push_back(expected);
endtask

task automatic load_vectors();
	// quotient mode
	add_vector("q_div_one",      32'h0000_1234, 16'h0001, 1'b1, 1'b1, 16'h1234);
	add_vector("q_div_one_max",  32'h0000_ffff, 16'h0001, 1'b1, 1'b1, 16'hffff);
	add_vector("q_max_high",     32'hfffe_ffff, 16'hffff, 1'b1, 1'b1, 16'hffff);
	add_vector("q_small",        32'h0000_0005, 16'h0007, 1'b1, 1'b1, 16'h0000);
	add_vector("q_zero",         32'h0000_0000, 16'h1234, 1'b1, 1'b1, 16'h0000);
	add_vector("q_thousand",     32'h000f_4240, 16'h03e8, 1'b1, 1'b1, 16'h03e8);
	add_vector("q_mixed",        32'h1234_5678, 16'h4321, 1'b1, 1'b1, 16'h456c);
	add_vector("q_high_only",    32'h0001_0000, 16'h0003, 1'b1, 1'b1, 16'h5555);

	// remainder mode, even quotients end on a negative partial remainder
	add_vector("r_max_high",     32'hfffe_ffff, 16'hffff, 1'b0, 1'b1, 16'hfffe);
	add_vector("r_mixed",        32'h1234_5678, 16'h4321, 1'b0, 1'b1, 16'h1f8c);
	add_vector("r_thousand",     32'h000f_4240, 16'h03e8, 1'b0, 1'b1, 16'h0000);
	add_vector("r_exact",        32'h0000_ffff, 16'h0101, 1'b0, 1'b1, 16'h0000);
	add_vector("r_small",        32'h0000_0005, 16'h0007, 1'b0, 1'b1, 16'h0005);
	add_vector("r_div_one",      32'h0000_1234, 16'h0001, 1'b0, 1'b1, 16'h0000);
	add_vector("r_odd_quot",     32'h0000_0016, 16'h0007, 1'b0, 1'b1, 16'h0001);
	add_vector("r_even_quot",    32'h0000_0064, 16'h0007, 1'b0, 1'b1, 16'h0002);
	add_vector("r_high_only",    32'h0001_0000, 16'h0003, 1'b0, 1'b1, 16'h0001);

	// back to back, mode flips every item
	add_vector("alt_q0",         32'h00ab_cdef, 16'h0100, 1'b1, 1'b1, 16'habcd);
	add_vector("alt_r0",         32'h00ab_cdef, 16'h0100, 1'b0, 1'b1, 16'h00ef);
	add_vector("alt_q1",         32'h0000_0064, 16'h0007, 1'b1, 1'b1, 16'h000e);
	add_vector("alt_r1",         32'h0000_0064, 16'h0007, 1'b0, 1'b1, 16'h0002);
	add_vector("alt_q2",         32'h1234_5678, 16'h4321, 1'b1, 1'b1, 16'h456c);
	add_vector("alt_r2",         32'h1234_5678, 16'h4321, 1'b0, 1'b1, 16'h1f8c);

	// gaps of different lengths
	add_vector("idle",           32'h0000_0000, 16'h0001, 1'b0, 1'b0, 16'h0000);
	add_vector("idle",           32'h0000_0000, 16'h0001, 1'b0, 1'b0, 16'h0000);
	add_vector("gap_q",          32'h0000_0064, 16'h0007, 1'b1, 1'b1, 16'h000e);
	add_vector("idle",           32'h0000_0000, 16'h0001, 1'b0, 1'b0, 16'h0000);
	add_vector("gap_r",          32'h0000_0016, 16'h0007, 1'b0, 1'b1, 16'h0001);
	add_vector("idle",           32'h0000_0000, 16'h0001, 1'b0, 1'b0, 16'h0000);
	add_vector("idle",           32'h0000_0000, 16'h0001, 1'b0, 1'b0, 16'h0000);
	add_vector("idle",           32'h0000_0000, 16'h0001, 1'b0, 1'b0, 16'h0000);
	add_vector("gap_q2",         32'h000f_4240, 16'h03e8, 1'b1, 1'b1, 16'h03e8);
endtask

`endif

//--- bench/array_divider_tb.sv
`timescale 1ns/1ps

module array_divider_tb import div_pkg::*; ();

	localparam int ROWS_PER_STAGE = 4;
	localparam int NUM_STAGES = DIVISOR_W / ROWS_PER_STAGE;
	localparam int LATENCY = NUM_STAGES + 1;
	localparam int NUM_RANDOM = 200;
	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;

	logic      clk;
	logic      reset;
	logic      valid_input;
	dividend_t dividend;
	divisor_t  divisor;
	logic      mode;
	logic      valid_output;
	result_t   final_output;

	`include "div_vectors.svh"

	// items in flight, oldest first
	string   exp_name  [$];
	result_t exp_value [$];

	// input valid seen LATENCY cycles back
	logic valid_history [$];

	bit table_loaded = 1'b0;

	array_divider #(
		.ROWS_PER_STAGE (ROWS_PER_STAGE)
	) dut (
		.clk          (clk),
		.reset        (reset),
		.valid_input  (valid_input),
		.dividend     (dividend),
		.divisor      (divisor),
		.mode         (mode),
		.valid_output (valid_output),
		.final_output (final_output)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_error(string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_result(string name, result_t expected, result_t actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_valid(string name, logic expected, logic actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("Mismatch %s: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	// one item per cycle, just after the rising edge
	task automatic drive_item(string name, dividend_t dvd, divisor_t dvs, logic md, logic vld,
			result_t expected);
		@(posedge clk);
		#DRIVE_DELAY;
		valid_input = vld;
		dividend = dvd;
		divisor = dvs;
		mode = md;
		if (vld) begin
			exp_name.push_back(name);
			exp_value.push_back(expected);
		end
	endtask

	// outputs are compared at the falling edge
	initial begin : monitor
		logic    exp_valid;
		string   name;
		result_t value;

		repeat (LATENCY) valid_history.push_back(1'b0);
		@(posedge clk);
		forever begin
			@(negedge clk);
			valid_history.push_back(valid_input);
			exp_valid = valid_history.pop_front();
			check_valid($sformatf("valid_output at %0t", $time), exp_valid, valid_output);
			if (valid_output === 1'b1) begin
				name = exp_name.pop_front();
				value = exp_value.pop_front();
				check_result(name, value, final_output);
			end
		end
	end

	initial begin : stimulus
		dividend_t dvd;
		divisor_t  dvs;
		logic      md;
		dividend_t full;

		reset = 1'b1;
		valid_input = 1'b0;
		dividend = '0;
		divisor = 16'h0001;
		mode = 1'b0;
		void'($urandom(13));
		load_vectors();
		table_loaded = 1'b1;

		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		for (int i = 0; i < vec_name.size(); i++) begin
			drive_item(vec_name[i], vec_dividend[i], vec_divisor[i], vec_mode[i],
				vec_valid[i], vec_expected[i]);
		end

		// legal pairs need the high half below the divisor
		for (int i = 0; i < NUM_RANDOM; i++) begin
			dvs = divisor_t'($urandom);
			if (dvs == '0) begin
				dvs = 16'h0001;
			end
			dvd[DIVIDEND_W-1:DIVISOR_W] = divisor_t'($urandom % dvs);
			dvd[DIVISOR_W-1:0] = divisor_t'($urandom);
			md = 1'($urandom & 32'd1);
			full = md ? dvd / dvs : dvd % dvs;
			drive_item($sformatf("random_%0d", i), dvd, dvs, md, 1'b1, full[DIVISOR_W-1:0]);
		end

		drive_item("idle", '0, 16'h0001, 1'b0, 1'b0, '0);
		while (exp_value.size() != 0) @(posedge clk);

		// valid_output has to stay low once the pipe drains
		repeat (LATENCY + 2) @(posedge clk);
		$display("Test completed successfully");
		$finish;
	end

	initial begin : watchdog
		wait (table_loaded);
		#((vec_name.size() + NUM_RANDOM + LATENCY + 4 + 20) * CLK_PERIOD);
		$display("Timeout: the divider did not deliver all results in time");
		$display("Test failed");
		$fatal(1);
	end

endmodule

//--- verilog.f
+incdir+bench
hw/div_pkg.sv
hw/cas_row.sv
hw/div_stage.sv
hw/div_array.sv
hw/result_stage.sv
hw/array_divider.sv
bench/array_divider_tb.sv

//--- Bender.yml
package:
  name: array_divider

sources:
  # divider RTL in compile order
  - files:
      - hw/div_pkg.sv
      - hw/cas_row.sv
      - hw/div_stage.sv
      - hw/div_array.sv
      - hw/result_stage.sv
      - hw/array_divider.sv

  # testbench with its vector table header
  - target: test
    include_dirs:
      - bench
    files:
      - bench/array_divider_tb.sv
